/* compile.f */
+incdir+.
io_pkg.sv
io_bus_if.sv
io_bridge.sv
io_port_decoder.sv
io_port_regs.sv
io_resp_merge.sv
io_subsys_top.sv
io_subsys_tb.sv

/* io_bridge.sv */
// splits cpu port reads and writes into aligned word transactions and stitches read data
module io_bridge import io_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    // cpu side
    input  logic        io_read_do,
    input  logic        io_write_do,
    input  logic        dcache_busy,
    input  io_addr_u    io_read_address,
    input  io_addr_u    io_write_address,
    input  io_len_e     io_read_length,
    input  io_len_e     io_write_length,
    input  logic [31:0] io_write_data,
    output logic [31:0] io_read_data,
    output logic        io_read_done,
    output logic        io_write_done,

    // word bus
    io_bus_if.host      bus
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WRITE_1,
        ST_WRITE_2,
        ST_READ_1,
        ST_READ_2
    } state_e;

    state_e      state;

    logic [7:0]  wr_be;        // both words, low nibble first
    logic [63:0] wr_data;      // data moved into its lanes
    logic        wr_split;
    logic [15:0] wr_next;
    logic [7:0]  rd_be;
    logic        rd_split;
    logic [15:0] rd_next;
    logic [4:0]  rd_shift;     // lane in bits
    logic [31:0] rd_first;
    logic [31:0] rd_stitch;
    logic        start_write;
    logic        start_read;
    logic        wr_second;
    logic        rd_second;

    // byte mask of the access before it is moved to its lane
    function automatic logic [3:0] len_mask(input io_len_e len);
        case (len)
            LEN_1:   len_mask = 4'b0001;
            LEN_2:   len_mask = 4'b0011;
            default: len_mask = 4'b1111;
        endcase
    endfunction

    // --------------------------------------------------
    // write side lanes
    // --------------------------------------------------
    assign wr_be    = {4'b0000, len_mask(io_write_length)} << io_write_address.raw[1:0];
    assign wr_data  = {32'd0, io_write_data} << {io_write_address.raw[1:0], 3'b000};
    assign wr_split = |wr_be[7:4];                   // bytes spill into next word
    assign wr_next  = io_write_address.raw + 16'd4;

    // --------------------------------------------------
    // read side lanes
    // --------------------------------------------------
    assign rd_be    = {4'b0000, len_mask(io_read_length)} << io_read_address.raw[1:0];
    assign rd_split = |rd_be[7:4];
    assign rd_next  = io_read_address.raw + 16'd4;
    assign rd_shift = {io_read_address.raw[1:0], 3'b000};

    // first word slides down to bit 0
    assign rd_first  = bus.readdata >> rd_shift;
    // second word sits above the bytes already held
    assign rd_stitch = (bus.readdata << (6'd32 - {1'b0, rd_shift}))
                     | (io_read_data & (32'hFFFF_FFFF >> rd_shift));

    // --------------------------------------------------
    // launch conditions
    // --------------------------------------------------
    // the done check keeps a still-held do from restarting the same access
    assign start_write = (state == ST_IDLE) && io_write_do && !io_write_done
                      && !dcache_busy;
    assign start_read  = (state == ST_IDLE) && !start_write && io_read_do
                      && !io_read_done && !dcache_busy;
    assign wr_second   = (state == ST_WRITE_1) && !bus.waitrequest && wr_split;
    assign rd_second   = (state == ST_READ_1) && bus.readdatavalid && rd_split;

    // --------------------------------------------------
    // fsm and strobes
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= ST_IDLE;
            bus.read      <= 1'b0;
            bus.write     <= 1'b0;
            io_read_done  <= 1'b0;
            io_write_done <= 1'b0;
        end else begin
            io_read_done  <= 1'b0; // pulses
            io_write_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start_write) begin
                        bus.write <= 1'b1;
                        state     <= ST_WRITE_1;
                    end else if (start_read) begin
                        bus.read <= 1'b1;
                        state    <= ST_READ_1;
                    end
                end
                ST_WRITE_1: begin
                    if (!bus.waitrequest) begin
                        if (wr_split) begin
                            state <= ST_WRITE_2; // strobe stays up, next word
                        end else begin
                            bus.write     <= 1'b0;
                            io_write_done <= 1'b1;
                            state         <= ST_IDLE;
                        end
                    end
                end
                ST_WRITE_2: begin
                    if (!bus.waitrequest) begin
                        bus.write     <= 1'b0;
                        io_write_done <= 1'b1;
                        state         <= ST_IDLE;
                    end
                end
                ST_READ_1: begin
                    if (bus.read && !bus.waitrequest) bus.read <= 1'b0; // taken
                    if (bus.readdatavalid) begin
                        if (rd_split) begin
                            bus.read <= 1'b1;
                            state    <= ST_READ_2;
                        end else begin
                            io_read_done <= 1'b1;
                            state        <= ST_IDLE;
                        end
                    end
                end
                ST_READ_2: begin
                    if (bus.read && !bus.waitrequest) bus.read <= 1'b0;
                    if (bus.readdatavalid) begin
                        io_read_done <= 1'b1;
                        state        <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // --------------------------------------------------
    // address, enables and data
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (start_write) begin
            bus.address    <= {io_write_address.raw[15:2], 2'b00};
            bus.byteenable <= wr_be[3:0];
            bus.writedata  <= wr_data[31:0];
        end else if (start_read) begin
            bus.address    <= {io_read_address.raw[15:2], 2'b00};
            bus.byteenable <= rd_be[3:0];
        end else if (wr_second) begin
            bus.address    <= {wr_next[15:2], 2'b00};
            bus.byteenable <= wr_be[7:4];
            bus.writedata  <= wr_data[63:32];
        end else if (rd_second) begin
            bus.address    <= {rd_next[15:2], 2'b00};
            bus.byteenable <= rd_be[7:4];
        end
        if (state == ST_READ_1 && bus.readdatavalid) io_read_data <= rd_first;
        if (state == ST_READ_2 && bus.readdatavalid) io_read_data <= rd_stitch;
    end

    // one strobe at a time across all bus phases
    a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        !(bus.read && bus.write));

    // every launched phase carries at least one byte
    a_be_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        (bus.read || bus.write) |-> (bus.byteenable != 4'b0000));

endmodule

/* io_bus_if.sv */
// word bus with wait request and byte enables, links the bridge, decoder, windows and merge
interface io_bus_if;

    // --------------------------------------------------
    // request side
    // --------------------------------------------------
    logic [15:0] address;      // always word aligned
    logic [3:0]  byteenable;
    logic        read;
    logic        write;
    logic [31:0] writedata;

    // --------------------------------------------------
    // response side
    // --------------------------------------------------
    logic        waitrequest;   // low = request taken this cycle
    logic        readdatavalid; // single cycle per read
    logic [31:0] readdata;

    // cpu side master
    modport host (
        output address, byteenable, read, write, writedata,
        input  waitrequest, readdatavalid, readdata
    );

    // register window
    modport device (
        input  address, byteenable, read, write, writedata,
        output waitrequest, readdatavalid, readdata
    );

    // address decode, looks at the request only
    modport req_tap (input address, byteenable, read, write, writedata);

    // response driver, read strobe tells reads from writes
    modport resp_src (output waitrequest, readdatavalid, readdata, input read);

    // response collection from a window
    modport resp_tap (input waitrequest, readdatavalid, readdata);

endinterface

/* io_consts.svh */
// port map and register window geometry, included by the rtl and the testbench
`ifndef IO_CONSTS_SVH
`define IO_CONSTS_SVH

// --------------------------------------------------
// port map
// --------------------------------------------------
`define IO_BASE       16'h0300  // first mapped port
`define IO_PAGE_BITS  10        // upper address bits that pick the page

// --------------------------------------------------
// window geometry
// --------------------------------------------------
`define IO_WINDOWS    4         // register windows in the bank
`define IO_REGS       4         // 32-bit registers per window

// floating isa bus reads back all ones
`define IO_FLOAT_BYTE 8'hFF

`endif

/* io_pkg.sv */
// shared types for the i/o port subsystem, imported by the bridge, decoder and windows
`include "io_consts.svh"

package io_pkg;

    // field view of a port address
    typedef struct packed {
        logic [`IO_PAGE_BITS-1:0]    page;    // compared against the mapped page
        logic [1:0]                  window;  // which register window
        logic [$clog2(`IO_REGS)-1:0] regsel;  // register inside the window
        logic [1:0]                  lane;    // byte lane inside the word
    } io_addr_fields_t;

    // same 16 bits, raw for arithmetic, fields for decode
    typedef union packed {
        logic [15:0]     raw;
        io_addr_fields_t f;
    } io_addr_u;

    // access length in bytes
    typedef enum logic [2:0] {
        LEN_1 = 3'd1,
        LEN_2 = 3'd2,
        LEN_4 = 3'd4
    } io_len_e;

endpackage

/* io_port_decoder.sv */
// routes word bus requests to one register window or flags them as unmapped
`include "io_consts.svh"

module io_port_decoder import io_pkg::*; (
    io_bus_if.req_tap bus,                  // from the bridge
    io_bus_if.host    win [`IO_WINDOWS],    // request side of each window
    output logic      unmapped
);

    localparam logic [15:0]              BASE_ADDR = `IO_BASE;
    localparam logic [`IO_PAGE_BITS-1:0] BASE_PAGE = BASE_ADDR[15 -: `IO_PAGE_BITS];

    io_addr_u addr;
    logic     page_hit;
    logic     active;

    assign addr     = bus.address;
    assign page_hit = (addr.f.page == BASE_PAGE);
    assign active   = bus.read || bus.write;

    // out of page, merge answers it
    assign unmapped = active && !page_hit;

    // --------------------------------------------------
    // per window request
    // --------------------------------------------------
    for (genvar g = 0; g < `IO_WINDOWS; g++) begin : g_win
        logic hit;

        assign hit = page_hit && (addr.f.window == 2'(g));

        // payload fans out, strobes only to the hit window
        assign win[g].address    = bus.address;
        assign win[g].byteenable = bus.byteenable;
        assign win[g].writedata  = bus.writedata;
        assign win[g].read       = bus.read  && hit;
        assign win[g].write      = bus.write && hit;
    end

endmodule

/* io_port_regs.sv */
// one register window, byte enable writes, a single wait state and registered read data
`include "io_consts.svh"

module io_port_regs import io_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    io_bus_if.device bus
);

    io_addr_u    addr;
    logic [31:0] regs [`IO_REGS];
    logic        wait_q;     // second cycle of a request
    logic        sel;
    logic        wr_accept;
    logic        rd_accept;

    assign addr = bus.address;
    assign sel  = bus.read || bus.write;

    // --------------------------------------------------
    // wait state
    // --------------------------------------------------
    // high in the first cycle of a request, low in the second
    assign bus.waitrequest = sel && !wait_q;
    assign wr_accept       = bus.write && wait_q;
    assign rd_accept       = bus.read  && wait_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_q <= 1'b0;
        end else begin
            wait_q <= sel && !wait_q; // clears on accept so back to back phases wait again
        end
    end

    // --------------------------------------------------
    // storage
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < `IO_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (wr_accept) begin
            for (int b = 0; b < 4; b++) begin
                if (bus.byteenable[b]) regs[addr.f.regsel][8*b +: 8] <= bus.writedata[8*b +: 8];
            end
        end
    end

    // --------------------------------------------------
    // read response
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus.readdatavalid <= 1'b0;
        end else begin
            bus.readdatavalid <= rd_accept; // one cycle after accept
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) bus.readdata <= regs[addr.f.regsel]; // whole word, bridge picks bytes
    end

    // decoder passes one strobe through at a time
    a_win_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        !(bus.read && bus.write));

endmodule

/* io_resp_merge.sv */
// collects window responses onto the cpu side bus and answers unmapped accesses
`include "io_consts.svh"

module io_resp_merge (
    input  logic       clk,
    input  logic       rst_n,
    io_bus_if.resp_tap win [`IO_WINDOWS],
    input  logic       unmapped,
    io_bus_if.resp_src bus
);

    logic [`IO_WINDOWS-1:0] wait_vec;
    logic [`IO_WINDOWS-1:0] rdv_vec;
    logic [31:0]            data_gated [`IO_WINDOWS];
    logic [31:0]            data_or;
    logic                   float_rdv;   // floating bus data phase

    // --------------------------------------------------
    // window taps
    // --------------------------------------------------
    for (genvar g = 0; g < `IO_WINDOWS; g++) begin : g_tap
        assign wait_vec[g]   = win[g].waitrequest;
        assign rdv_vec[g]    = win[g].readdatavalid;
        assign data_gated[g] = win[g].readdata & {32{win[g].readdatavalid}};
    end

    always_comb begin
        data_or = '0;
        for (int i = 0; i < `IO_WINDOWS; i++) begin
            data_or = data_or | data_gated[i];
        end
    end

    // --------------------------------------------------
    // unmapped reads
    // --------------------------------------------------
    // no wait, data one cycle after the accept
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            float_rdv <= 1'b0;
        end else begin
            float_rdv <= unmapped && bus.read; // writes are just dropped
        end
    end

    // --------------------------------------------------
    // cpu side response
    // --------------------------------------------------
    assign bus.waitrequest   = |wait_vec;   // unselected windows sit at zero
    assign bus.readdatavalid = |rdv_vec || float_rdv;
    assign bus.readdata      = float_rdv ? {4{`IO_FLOAT_BYTE}} : data_or;

    // only the addressed window ever answers
    a_rdv_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(rdv_vec));

endmodule

/* io_subsys_tb.sv */
// table-driven testbench for the i/o port subsystem, checks port reads against a byte shadow
`include "io_consts.svh"

module io_subsys_tb import io_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int OP_RD     = 0;
    localparam int OP_WR     = 1;
    localparam int OP_BOTH   = 2;                           // write and read raised together
    localparam int MAP_BYTES = `IO_WINDOWS * `IO_REGS * 4;  // 64 mapped ports
    localparam int TIMEOUT   = 50;                          // cycles per done wait

    logic        clk;
    logic        rst_n;
    logic        io_read_do;
    io_addr_u    io_read_address;
    io_len_e     io_read_length;
    logic [31:0] io_read_data;
    logic        io_read_done;
    logic        io_write_do;
    io_addr_u    io_write_address;
    io_len_e     io_write_length;
    logic [31:0] io_write_data;
    logic        io_write_done;
    logic        dcache_busy;

    // stimulus table, one entry per access
    string       t_name [$];
    int          t_op   [$];
    logic [15:0] t_addr [$];
    io_len_e     t_len  [$];
    logic [31:0] t_data [$];
    int          t_hold [$];    // cycles of dcache_busy before the access may start

    logic [7:0]  shadow [MAP_BYTES];   // expected contents of the mapped ports
    integer      seed;
    int          value_errors;
    int          timeout_errors;
    int          other_errors;

    io_subsys_top io_subsys_top_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .io_read_do       (io_read_do),
        .io_read_address  (io_read_address),
        .io_read_length   (io_read_length),
        .io_read_data     (io_read_data),
        .io_read_done     (io_read_done),
        .io_write_do      (io_write_do),
        .io_write_address (io_write_address),
        .io_write_length  (io_write_length),
        .io_write_data    (io_write_data),
        .io_write_done    (io_write_done),
        .dcache_busy      (dcache_busy)
    );

    always #20 clk = ~clk;  // 40 ns period

    // --------------------------------------------------
    // shadow model
    // --------------------------------------------------
    function automatic bit is_mapped(input logic [15:0] a);
        return (a >= `IO_BASE) && (a < `IO_BASE + MAP_BYTES);
    endfunction

    // bytes of the access that are compared
    function automatic logic [31:0] lane_mask(input io_len_e len);
        case (len)
            LEN_1:   return 32'h0000_00FF;
            LEN_2:   return 32'h0000_FFFF;
            default: return 32'hFFFF_FFFF;
        endcase
    endfunction

    function automatic logic [31:0] model_read(input logic [15:0] addr, input io_len_e len);
        logic [31:0] word;
        logic [15:0] a;
        word = '0;
        for (int i = 0; i < int'(len); i++) begin
            a = addr + 16'(i);
            word[8*i +: 8] = is_mapped(a) ? shadow[a - `IO_BASE] : `IO_FLOAT_BYTE;
        end
        return word;
    endfunction

    function automatic void model_write(input logic [15:0] addr, input io_len_e len,
                                        input logic [31:0] data);
        logic [15:0] a;
        for (int i = 0; i < int'(len); i++) begin
            a = addr + 16'(i);
            if (is_mapped(a)) shadow[a - `IO_BASE] = data[8*i +: 8]; // unmapped bytes vanish
        end
    endfunction

    // --------------------------------------------------
    // table build
    // --------------------------------------------------
    task automatic add_row(input string name, input int op, input logic [15:0] addr,
                           input io_len_e len, input logic [31:0] data, input int hold);
        t_name.push_back(name);
        t_op.push_back(op);
        t_addr.push_back(addr);
        t_len.push_back(len);
        t_data.push_back(data);
        t_hold.push_back(hold);
    endtask

    task automatic build_table();
        // every register reads zero out of reset
        for (int k = 0; k < `IO_WINDOWS * `IO_REGS; k++) begin
            add_row($sformatf("reset_w%0d_r%0d", k / `IO_REGS, k % `IO_REGS), OP_RD,
                    16'(`IO_BASE + 4 * k), LEN_4, 32'd0, 0);
        end
        // aligned writes, neighbours must survive
        add_row("wr_byte",         OP_WR,   16'h0305, LEN_1, 32'h0000_00A5, 0);
        add_row("rd_byte_word",    OP_RD,   16'h0304, LEN_4, 32'd0, 0);
        add_row("wr_half",         OP_WR,   16'h030A, LEN_2, 32'h0000_BEEF, 0);
        add_row("rd_half_word",    OP_RD,   16'h0308, LEN_4, 32'd0, 0);
        add_row("wr_word",         OP_WR,   16'h0314, LEN_4, $random(seed), 0);
        add_row("rd_word",         OP_RD,   16'h0314, LEN_4, 32'd0, 0);
        add_row("wr_byte_in_word", OP_WR,   16'h0316, LEN_1, 32'h0000_005A, 0);
        add_row("rd_byte_in_word", OP_RD,   16'h0314, LEN_4, 32'd0, 0);
        add_row("rd_half_lane2",   OP_RD,   16'h0316, LEN_2, 32'd0, 0);
        // two-word accesses over register and window edges
        add_row("wr_half_lane3",   OP_WR,   16'h0303, LEN_2, $random(seed), 0);
        add_row("rd_half_lane3",   OP_RD,   16'h0303, LEN_2, 32'd0, 0);
        add_row("rd_lane3_lo",     OP_RD,   16'h0300, LEN_4, 32'd0, 0);
        add_row("wr_word_lane1",   OP_WR,   16'h030D, LEN_4, $random(seed), 0);
        add_row("rd_word_lane1",   OP_RD,   16'h030D, LEN_4, 32'd0, 0);
        add_row("rd_win1_reg0",    OP_RD,   16'h0310, LEN_4, 32'd0, 0);
        add_row("wr_word_lane2",   OP_WR,   16'h0326, LEN_4, $random(seed), 0);
        add_row("rd_word_lane2",   OP_RD,   16'h0326, LEN_4, 32'd0, 0);
        add_row("wr_word_lane3",   OP_WR,   16'h032F, LEN_4, $random(seed), 0);
        add_row("rd_word_lane3",   OP_RD,   16'h032F, LEN_4, 32'd0, 0);
        add_row("rd_win2_reg3",    OP_RD,   16'h032C, LEN_4, 32'd0, 0);
        // outside the window bank
        add_row("rd_unmapped_low", OP_RD,   16'h0000, LEN_4, 32'd0, 0);
        add_row("rd_unmapped_end", OP_RD,   16'h0340, LEN_2, 32'd0, 0);
        add_row("rd_unmapped_hi",  OP_RD,   16'h8001, LEN_1, 32'd0, 0);
        add_row("wr_unmapped",     OP_WR,   16'h0400, LEN_4, 32'hDEAD_BEEF, 0);
        add_row("wr_alias",        OP_WR,   16'h0700, LEN_4, 32'h1234_5678, 0); // low bits = 0x300
        add_row("rd_after_alias",  OP_RD,   16'h0300, LEN_4, 32'd0, 0);
        add_row("wr_edge",         OP_WR,   16'h033E, LEN_4, $random(seed), 0);
        add_row("rd_edge",         OP_RD,   16'h033E, LEN_4, 32'd0, 0);
        add_row("rd_below_base",   OP_RD,   16'h02FE, LEN_4, 32'd0, 0);
        // dcache busy holds the start off
        add_row("wr_busy",         OP_WR,   16'h0318, LEN_4, $random(seed), 3);
        add_row("rd_busy",         OP_RD,   16'h0318, LEN_4, 32'd0, 5);
        add_row("rd_busy_split",   OP_RD,   16'h031B, LEN_2, 32'd0, 8);
        // write wins over a read raised in the same cycle
        add_row("both_word",       OP_BOTH, 16'h0320, LEN_4, $random(seed), 0);
        add_row("both_split",      OP_BOTH, 16'h0337, LEN_2, $random(seed), 0);
    endtask

    // --------------------------------------------------
    // cycle helpers
    // --------------------------------------------------
    task automatic step_cycle();
        @(posedge clk);
        #2;  // drive and sample away from the edge
    endtask

    // no done may pulse over these cycles
    task automatic idle_cycles(input int n, input string why);
        for (int c = 0; c < n; c++) begin
            step_cycle();
            if (io_read_done || io_write_done) begin
                $display("unexpected done pulse %s", why);
                other_errors++;
            end
        end
    endtask

    task automatic wait_done(input bit is_write, input string name);
        bit seen;
        seen = 1'b0;
        for (int c = 0; c < TIMEOUT && !seen; c++) begin
            step_cycle();
            if (is_write ? io_write_done : io_read_done) begin
                seen = 1'b1;
            end else if (is_write ? io_read_done : io_write_done) begin
                $display("%s: the other done pulsed while waiting", name);
                other_errors++;
            end
        end
        if (!seen) begin
            $display("%s: no %s done within %0d cycles", name, is_write ? "write" : "read",
                     TIMEOUT);
            timeout_errors++;
        end
        if (is_write) io_write_do = 1'b0;   // cpu drops the request after done
        else io_read_do = 1'b0;
    endtask

    task automatic check_read(input string name, input logic [15:0] addr, input io_len_e len);
        logic [31:0] expected;
        logic [31:0] actual;
        expected = model_read(addr, len);
        actual   = io_read_data & lane_mask(len);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %08h, actual %08h", name, expected, actual);
            value_errors++;
        end
    endtask

    // --------------------------------------------------
    // one table row
    // --------------------------------------------------
    task automatic run_row(input int i);
        if (t_op[i] != OP_RD) begin
            io_write_address.raw = t_addr[i];
            io_write_length      = t_len[i];
            io_write_data        = t_data[i];
            io_write_do          = 1'b1;
        end
        if (t_op[i] != OP_WR) begin
            io_read_address.raw = t_addr[i];
            io_read_length      = t_len[i];
            io_read_do          = 1'b1;
        end
        if (t_hold[i] > 0) begin
            dcache_busy = 1'b1;
            idle_cycles(t_hold[i], {"while dcache busy in ", t_name[i]});
            dcache_busy = 1'b0;
        end
        if (t_op[i] != OP_RD) begin
            wait_done(1'b1, t_name[i]);
            model_write(t_addr[i], t_len[i], t_data[i]);
        end
        if (t_op[i] != OP_WR) begin
            wait_done(1'b0, t_name[i]);
            check_read(t_name[i], t_addr[i], t_len[i]);
        end
        idle_cycles(1, {"after ", t_name[i]});
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        seed                 = 81194;
        clk                  = 1'b0;
        rst_n                = 1'b0;
        io_read_do           = 1'b0;
        io_read_address.raw  = 16'h0000;
        io_read_length       = LEN_1;
        io_write_do          = 1'b0;
        io_write_address.raw = 16'h0000;
        io_write_length      = LEN_1;
        io_write_data        = 32'd0;
        dcache_busy          = 1'b0;
        value_errors         = 0;
        timeout_errors       = 0;
        other_errors         = 0;
        for (int b = 0; b < MAP_BYTES; b++) begin
            shadow[b] = 8'h00;
        end
        build_table();

        idle_cycles(4, "in reset");
        rst_n = 1'b1;
        idle_cycles(3, "after reset");

        for (int i = 0; i < t_name.size(); i++) begin
            run_row(i);
        end

        $display("errors: %0d value, %0d timeout, %0d other", value_errors, timeout_errors,
                 other_errors);
        if (value_errors + timeout_errors + other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* io_subsys_top.sv */
// i/o port subsystem top, cpu side on plain ports, bridge to decoder to windows to merge
`include "io_consts.svh"

module io_subsys_top import io_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    // port read
    input  logic        io_read_do,
    input  io_addr_u    io_read_address,
    input  io_len_e     io_read_length,
    output logic [31:0] io_read_data,
    output logic        io_read_done,

    // port write
    input  logic        io_write_do,
    input  io_addr_u    io_write_address,
    input  io_len_e     io_write_length,
    input  logic [31:0] io_write_data,
    output logic        io_write_done,

    input  logic        dcache_busy
);

    io_bus_if cpu_bus ();                    // bridge side word bus
    io_bus_if win_bus [`IO_WINDOWS] ();      // one per window

    logic unmapped;

    // --------------------------------------------------
    // cpu side
    // --------------------------------------------------
    io_bridge io_bridge_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .io_read_do       (io_read_do),
        .io_write_do      (io_write_do),
        .dcache_busy      (dcache_busy),
        .io_read_address  (io_read_address),
        .io_write_address (io_write_address),
        .io_read_length   (io_read_length),
        .io_write_length  (io_write_length),
        .io_write_data    (io_write_data),
        .io_read_data     (io_read_data),
        .io_read_done     (io_read_done),
        .io_write_done    (io_write_done),
        .bus              (cpu_bus)
    );

    // --------------------------------------------------
    // decode, windows, merge
    // --------------------------------------------------
    io_port_decoder io_port_decoder_i (
        .bus      (cpu_bus),
        .win      (win_bus),
        .unmapped (unmapped)
    );

    for (genvar g = 0; g < `IO_WINDOWS; g++) begin : g_regs
        io_port_regs io_port_regs_i (
            .clk   (clk),
            .rst_n (rst_n),
            .bus   (win_bus[g])
        );
    end

    io_resp_merge io_resp_merge_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .win      (win_bus),
        .unmapped (unmapped),
        .bus      (cpu_bus)
    );

endmodule
